// ==== credit_pkg.sv ====
`default_nettype none

// Shared definitions for the credit-based flit link
package credit_pkg;

  // ------------------------------------------------------------------
  // Link sizing
  // ------------------------------------------------------------------

  // Receive buffer entries, which is also the credit count at reset
  // Six is deliberately not a power of two so the pointers need wrap correction
  localparam int LINK_DEPTH = 6;

  // A credit counter or fill level spans 0..LINK_DEPTH inclusive
  localparam int CNT_W = $clog2(LINK_DEPTH + 1);

  // A buffer pointer spans 0..LINK_DEPTH-1, never narrower than one bit
  localparam int PTR_W = (LINK_DEPTH > 1) ? $clog2(LINK_DEPTH) : 1;

  // Flit field widths
  localparam int TAG_W  = 4;
  localparam int DATA_W = 16;

  // ------------------------------------------------------------------
  // Flit format
  // ------------------------------------------------------------------

  // One flit as it travels from the producer through the link register
  // into the receive buffer and out to the consumer
  // The tag sits in the upper bits, the data below it, 20 bits in total
  typedef struct packed {
    // Small identifier, handy for following a flit through a waveform
    logic [TAG_W-1:0]  tag;
    // Payload word
    logic [DATA_W-1:0] data;
  } flit_t;

endpackage : credit_pkg

`default_nettype wire

// ==== credit_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

// Up/down counter moving by at most one per cycle
// The value can wrap around 0 and MAX_VALUE (inclusive), with an explicit
// correction step when MAX_VALUE+1 is not a power of two
// value_next exposes the value of the next cycle, so other logic can act on
// it without waiting for the register
// A reinit loads initial_value, and a change in the same cycle is applied on
// top of initial_value instead of the old value
module credit_counter #(
  // Largest value the counter may hold, inclusive
  parameter int MAX_VALUE = 1,
  // When set, the counter wraps at 0 and MAX_VALUE, otherwise it must stay in range
  parameter bit ENABLE_WRAP = 1'b1,
  // Width of the value, wide enough for MAX_VALUE
  parameter int VALUE_W = 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               reinit,
  input  logic [VALUE_W-1:0] initial_value,
  input  logic               incr_valid,
  input  logic               decr_valid,
  output logic [VALUE_W-1:0] value,
  output logic [VALUE_W-1:0] value_next
);

  // ------------------------------------------------------------------
  // Derived constants
  // ------------------------------------------------------------------

  // One extra bit catches both overflow past MAX_VALUE and underflow below 0
  localparam int TEMP_W = VALUE_W + 1;
  localparam logic [TEMP_W-1:0] MAX_EXT = TEMP_W'(MAX_VALUE);
  localparam logic [TEMP_W-1:0] MAX_P1 = TEMP_W'(MAX_VALUE + 1);
  // When MAX_VALUE+1 is a power of two, truncation wraps for free
  localparam bit MAX_P1_POW2 = (MAX_P1 & MAX_EXT) == '0;

  // ------------------------------------------------------------------
  // Next value
  // ------------------------------------------------------------------

  logic [VALUE_W-1:0] base;
  logic [TEMP_W-1:0]  value_temp;
  logic               load_en;

  // Reinit swaps the base so that a same-cycle change lands on initial_value
  assign base = reinit ? initial_value : value;

  // An underflow shows up as a large number with the extra bit set
  assign value_temp = {1'b0, base} + TEMP_W'(incr_valid) - TEMP_W'(decr_valid);

  // The register only moves when something asks it to
  assign load_en = reinit | incr_valid | decr_valid;

  if (ENABLE_WRAP && !MAX_P1_POW2) begin : g_wrap_fix
    logic               net_decr;
    logic               out_of_range;
    logic [TEMP_W-1:0]  value_wrapped;

    // With unit steps, a net decrement means exactly one decr and no incr
    assign net_decr     = decr_valid & ~incr_valid;
    assign out_of_range = value_temp > MAX_EXT;

    // Below zero folds up to MAX_VALUE, above MAX_VALUE folds down to zero
    always_comb begin
      value_wrapped = value_temp;
      if (out_of_range && net_decr) begin
        value_wrapped = value_temp + MAX_P1;
      end else if (out_of_range) begin
        value_wrapped = value_temp - MAX_P1;
      end
    end

    assign value_next = value_wrapped[VALUE_W-1:0];
  end else begin : g_plain
    // Either natural power-of-two wrap or no wrap at all
    assign value_next = value_temp[VALUE_W-1:0];

    if (!ENABLE_WRAP) begin : g_range_check
      // Without wrap, a change that leaves 0..MAX_VALUE is a caller error
      a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        value_temp <= MAX_EXT)
        else $error("credit_counter: change leaves 0..%0d", MAX_VALUE);
    end
  end

  // ------------------------------------------------------------------
  // State register
  // ------------------------------------------------------------------

  // Reset loads the same initial value that reinit uses
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= initial_value;
    end else if (load_en) begin
      value <= value_next;
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_value_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    value <= MAX_EXT)
    else $error("credit_counter: value above %0d", MAX_VALUE);

  // The look-ahead must match what the register actually captures
  a_next_propagates: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> value == $past(value_next))
    else $error("credit_counter: value does not follow value_next");

endmodule : credit_counter

`default_nettype wire

// ==== credit_sender.sv ====
`timescale 1ns/1ns
`default_nettype none

// Sending side of the link
// Holds one credit per free receive buffer entry, spends a credit on each
// push, and gets it back when the receiver pops the entry
module credit_sender import credit_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  flit_t            push_flit,
  input  logic             flush,
  input  logic             credit_return,
  output logic             link_valid,
  output flit_t            link_flit,
  output logic             credit_avail,
  output logic [CNT_W-1:0] credit_count
);

  logic [CNT_W-1:0] count_next;

  // ------------------------------------------------------------------
  // Credit counter
  // ------------------------------------------------------------------

  // Starts full at LINK_DEPTH and never wraps
  // Flush refills it, and a push in the flush cycle still spends a credit
  credit_counter #(
    .MAX_VALUE   (LINK_DEPTH),
    .ENABLE_WRAP (1'b0),
    .VALUE_W     (CNT_W)
  ) credit_cnt_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reinit        (flush),
    .initial_value (CNT_W'(LINK_DEPTH)),
    .incr_valid    (credit_return),
    .decr_valid    (push),
    .value         (credit_count),
    .value_next    (count_next)
  );

  // Registered from the look-ahead so it lines up with credit_count
  // and the producer sees a clean flop output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_avail <= (LINK_DEPTH != 0);
    end else begin
      credit_avail <= (count_next != '0);
    end
  end

  // ------------------------------------------------------------------
  // Link register
  // ------------------------------------------------------------------

  // The valid pulse follows the push by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= push;
    end
  end

  // Payload only loads on a push
  always_ff @(posedge clk) begin
    if (push) begin
      link_flit <= push_flit;
    end
  end

  // Push is not gated here, so a push without credit would overrun the receiver
  a_push_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> credit_avail && credit_count != '0)
    else $error("credit_sender: push issued with no credit left");

endmodule : credit_sender

`default_nettype wire

// ==== credit_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// Receive side of the link
// A circular buffer of LINK_DEPTH entries whose pointers and fill level are
// all built from the shared counter, with one credit sent back per pop
module credit_fifo import credit_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             link_valid,
  input  flit_t            link_flit,
  input  logic             pop,
  output logic             pop_valid,
  output flit_t            pop_flit,
  output logic [CNT_W-1:0] fill_level,
  output logic             credit_return
);

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill_next;
  logic             pop_accept;
  flit_t            mem [LINK_DEPTH];

  // A pop that meets a flush is dropped, the flush empties the buffer anyway
  assign pop_accept = pop & ~flush;

  // ------------------------------------------------------------------
  // Pointers and fill level
  // ------------------------------------------------------------------

  // Both pointers wrap at LINK_DEPTH-1 with the non-power-of-two correction
  credit_counter #(
    .MAX_VALUE   (LINK_DEPTH - 1),
    .ENABLE_WRAP (1'b1),
    .VALUE_W     (PTR_W)
  ) wr_ptr_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reinit        (flush),
    .initial_value ('0),
    .incr_valid    (link_valid),
    .decr_valid    (1'b0),
    .value         (wr_ptr),
    .value_next    ()
  );

  credit_counter #(
    .MAX_VALUE   (LINK_DEPTH - 1),
    .ENABLE_WRAP (1'b1),
    .VALUE_W     (PTR_W)
  ) rd_ptr_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reinit        (flush),
    .initial_value ('0),
    .incr_valid    (pop_accept),
    .decr_valid    (1'b0),
    .value         (rd_ptr),
    .value_next    ()
  );

  // Fill level tells full from empty when the pointers are equal
  credit_counter #(
    .MAX_VALUE   (LINK_DEPTH),
    .ENABLE_WRAP (1'b0),
    .VALUE_W     (CNT_W)
  ) fill_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .reinit        (flush),
    .initial_value ('0),
    .incr_valid    (link_valid),
    .decr_valid    (pop_accept),
    .value         (fill_level),
    .value_next    (fill_next)
  );

  // ------------------------------------------------------------------
  // Storage and outputs
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (link_valid) begin
      mem[wr_ptr] <= link_flit;
    end
  end

  // Head entry is shown without a register stage
  assign pop_flit = mem[rd_ptr];

  // Taken from the look-ahead so it rises with the first stored entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_valid     <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      pop_valid     <= (fill_next != '0);
      credit_return <= pop_accept;
    end
  end

  // Credits should make a write into a full buffer impossible
  a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    link_valid |-> fill_level < CNT_W'(LINK_DEPTH))
    else $error("credit_fifo: write arrived with the buffer full");

  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> pop_valid)
    else $error("credit_fifo: pop issued with the buffer empty");

  // The three counters run separately and must agree modulo the depth
  a_ptrs_match_fill: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(wr_ptr) + LINK_DEPTH - int'(rd_ptr)) % LINK_DEPTH
      == int'(fill_level) % LINK_DEPTH)
    else $error("credit_fifo: pointers disagree with fill level");

endmodule : credit_fifo

`default_nettype wire

// ==== credit_link.sv ====
`timescale 1ns/1ns
`default_nettype none

// Top level of the credit-based flit link
// The sender drives the one-cycle link register into the receive buffer,
// and the buffer hands a credit back for every entry popped
module credit_link import credit_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  flit_t            push_flit,
  input  logic             flush,
  input  logic             pop,
  output logic             credit_avail,
  output logic [CNT_W-1:0] credit_count,
  output logic             pop_valid,
  output flit_t            pop_flit,
  output logic [CNT_W-1:0] fill_level
);

  // ------------------------------------------------------------------
  // Link between the two sides
  // ------------------------------------------------------------------

  logic  link_valid;
  flit_t link_flit;
  logic  credit_return;

  credit_sender credit_sender_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (push),
    .push_flit     (push_flit),
    .flush         (flush),
    .credit_return (credit_return),
    .link_valid    (link_valid),
    .link_flit     (link_flit),
    .credit_avail  (credit_avail),
    .credit_count  (credit_count)
  );

  credit_fifo credit_fifo_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .link_valid    (link_valid),
    .link_flit     (link_flit),
    .pop           (pop),
    .pop_valid     (pop_valid),
    .pop_flit      (pop_flit),
    .fill_level    (fill_level),
    .credit_return (credit_return)
  );

  // A quiet cycle before flush means no flit is on the link register and no
  // credit is on its way back, so both sides can restart from LINK_DEPTH
  a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    flush && $past(rst_n) |-> $past(!push && !pop))
    else $error("credit_link: flush without a quiet cycle before it");

endmodule : credit_link

`default_nettype wire

// ==== credit_link_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

// Testbench for the credit-based flit link
// A reference model runs next to the DUT, and concurrent assertions compare the two
module credit_link_tb import credit_pkg::*; ();

  logic             clk;
  logic             rst_n;
  logic             push;
  flit_t            push_flit;
  logic             flush;
  logic             pop;
  logic             credit_avail;
  logic [CNT_W-1:0] credit_count;
  logic             pop_valid;
  flit_t            pop_flit;
  logic [CNT_W-1:0] fill_level;

  // Model of every flit pushed, oldest at head_idx
  flit_t       model_mem [4096];
  logic [11:0] head_idx;
  logic [11:0] tail_idx;
  flit_t       exp_head;
  int          exp_credits;
  int          exp_fill;
  // Push and pop of one cycle earlier stand for the link flit and the credit in flight
  logic        push_d;
  logic        pop_d;
  logic        hold_pops;
  int          held_pushes;
  logic        empty_push;
  logic        zero_credit_pop;
  int          cycle_count = 0;

  credit_link credit_link_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_flit    (push_flit),
    .flush        (flush),
    .pop          (pop),
    .credit_avail (credit_avail),
    .credit_count (credit_count),
    .pop_valid    (pop_valid),
    .pop_flit     (pop_flit),
    .fill_level   (fill_level)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // The whole run takes about 1600 cycles, so 4000 is well over twice that
  always @(posedge clk) begin
    if (cycle_count >= 4000) begin
      $display("timeout: the run did not finish within 4000 cycles");
      $display("Verification failed");
      $fatal(1, "timeout");
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      head_idx    <= '0;
      tail_idx    <= '0;
      exp_credits <= LINK_DEPTH;
      exp_fill    <= 0;
      push_d      <= 1'b0;
      pop_d       <= 1'b0;
      held_pushes <= 0;
    end else begin
      push_d <= push;
      pop_d  <= pop && !flush;
      if (push) begin
        model_mem[tail_idx] <= push_flit;
        tail_idx            <= tail_idx + 12'd1;
      end
      // Flush drops every stored flit but keeps one pushed in the same cycle
      if (flush) begin
        head_idx    <= tail_idx;
        exp_credits <= LINK_DEPTH - int'(push);
        exp_fill    <= 0;
      end else begin
        if (pop) begin
          head_idx <= head_idx + 12'd1;
        end
        exp_credits <= exp_credits - int'(push) + int'(pop_d);
        exp_fill    <= exp_fill + int'(push_d) - int'(pop);
      end
      if (!hold_pops) begin
        held_pushes <= 0;
      end else if (push) begin
        held_pushes <= held_pushes + 1;
      end
    end
  end

  assign exp_head = model_mem[head_idx];
  // A push that finds nothing stored and nothing on the link
  assign empty_push = push && exp_fill == 0 && !push_d;
  // A pop while no credit is left and none is on its way back
  assign zero_credit_pop = pop && exp_credits == 0 && !pop_d;

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_order: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> pop_flit == exp_head)
    else report_mismatch("popped flit is not the oldest pushed flit");

  a_conserve: assert property (@(posedge clk) disable iff (!rst_n)
    int'(credit_count) + int'(fill_level) + int'(push_d) + int'(pop_d) == LINK_DEPTH)
    else report_mismatch("credits, stored and in-flight flits do not add up to the depth");

  a_credits: assert property (@(posedge clk) disable iff (!rst_n)
    int'(credit_count) == exp_credits && credit_avail == (exp_credits != 0))
    else report_mismatch("credit_count or credit_avail differs from the model");

  a_fill: assert property (@(posedge clk) disable iff (!rst_n)
    int'(fill_level) == exp_fill && pop_valid == (exp_fill != 0))
    else report_mismatch("fill_level or pop_valid differs from the model");

  a_push_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(empty_push, 2) |-> pop_valid && !$past(pop_valid))
    else report_mismatch("pop_valid did not rise two cycles after a push into empty");

  a_credit_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(zero_credit_pop, 2) |-> credit_avail && !$past(credit_avail))
    else report_mismatch("credit_avail did not rise two cycles after a pop at zero credits");

  a_exhaust_count: assert property (@(posedge clk) disable iff (!rst_n)
    hold_pops && $fell(credit_avail) |-> held_pushes == LINK_DEPTH && credit_count == '0)
    else report_mismatch("credit_avail fell after the wrong number of pushes");

  a_exhaust_fill: assert property (@(posedge clk) disable iff (!rst_n)
    hold_pops && !credit_avail && !push_d |-> fill_level == CNT_W'(LINK_DEPTH))
    else report_mismatch("buffer not full once the credits ran out");

  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    $past(flush) |-> !pop_valid && fill_level == '0
      && int'(credit_count) == LINK_DEPTH - int'($past(push)))
    else report_mismatch("wrong state in the cycle after a flush");

  a_reset: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rst_n) |-> int'(credit_count) == LINK_DEPTH && fill_level == '0
      && !pop_valid && credit_avail)
    else report_mismatch("wrong state in the first cycle after reset");

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  // Decided at the falling edge for the next cycle, so the estimates stay safe
  // even if a credit or a flit arrives in between
  function automatic logic may_push();
    return credit_count > CNT_W'(push);
  endfunction

  function automatic logic may_pop();
    return !flush && fill_level > CNT_W'(pop);
  endfunction

  task automatic drive_cycle(input logic do_push, input logic do_pop, input logic do_flush);
    flit_t next_flit;
    next_flit.tag  = TAG_W'($urandom);
    next_flit.data = DATA_W'($urandom);
    @(posedge clk);
    push      <= do_push;
    pop       <= do_pop;
    flush     <= do_flush;
    push_flit <= next_flit;
    @(negedge clk);
  endtask

  task automatic run_random(input int cycles);
    logic p;
    logic q;
    repeat (cycles) begin
      p = may_push() && ($urandom % 5) < 3;
      q = may_pop() && ($urandom % 2) == 1;
      drive_cycle(p, q, 1'b0);
    end
  endtask

  // Pops until every credit is back and no push is still being driven
  task automatic drain();
    while (int'(credit_count) != LINK_DEPTH || push) begin
      drive_cycle(1'b0, may_pop(), 1'b0);
    end
  endtask

  task automatic fill_and_drain();
    drain();
    hold_pops = 1'b1;
    while (credit_count != '0 || int'(fill_level) != LINK_DEPTH) begin
      drive_cycle(may_push(), 1'b0, 1'b0);
    end
    hold_pops = 1'b0;
    drain();
  endtask

  task automatic isolated_pushes(input int trials);
    repeat (trials) begin
      drain();
      repeat (int'($urandom % 3)) drive_cycle(1'b0, 1'b0, 1'b0);
      drive_cycle(1'b1, 1'b0, 1'b0);
    end
    drain();
  endtask

  task automatic flush_trial(input logic with_push);
    int n;
    n = int'($urandom % 5);
    repeat (n) drive_cycle(may_push(), 1'b0, 1'b0);
    // A quiet cycle leaves no flit and no credit in flight at the flush
    drive_cycle(1'b0, 1'b0, 1'b0);
    drive_cycle(with_push && credit_count != '0, 1'b0, 1'b1);
    run_random(8);
  endtask

  initial begin
    void'($urandom(96612));
    rst_n     <= 1'b0;
    push      <= 1'b0;
    pop       <= 1'b0;
    flush     <= 1'b0;
    push_flit <= '0;
    hold_pops = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    run_random(1200);
    repeat (3) fill_and_drain();
    isolated_pushes(8);
    for (int i = 0; i < 20; i++) begin
      flush_trial(i % 2 == 1);
    end
    drain();
    repeat (2) drive_cycle(1'b0, 1'b0, 1'b0);
    $display("Verification passed");
    $finish;
  end

endmodule : credit_link_tb

`default_nettype wire

// ==== flist.f ====
credit_pkg.sv
credit_counter.sv
credit_sender.sv
credit_fifo.sv
credit_link.sv
credit_link_tb.sv

// ==== Makefile ====
# Verilator build and run for the credit-based flit link
# Any variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= credit_link_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Verification failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS FAIL_MSG"

# The log decides the result, the simulator status backs it up
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test FAILED, see $(LOG)"; exit 1; \
	elif [ $$status -ne 0 ]; then \
	  echo "simulator exited with status $$status"; exit 1; \
	else \
	  echo "test finished cleanly"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
